// File: common/eth_fd_params.svh
/*
	Rule memory path parameters. Bus width, lane widths, rule memory
	depth and rule memory latency.
*/
`ifndef ETH_FD_PARAMS_SVH
`define ETH_FD_PARAMS_SVH

// Host bus width, a multiple of 32.
`define ETH_FD_AXI_WIDTH 32
`define ETH_FD_LANES (`ETH_FD_AXI_WIDTH / 32)

// Stored bits per 32-bit lane.
`define ETH_FD_LANE_BITS 30

`define ETH_FD_MEM_AWIDTH 11
`define ETH_FD_MEM_LAT 2 // Cycles from req to ack.

`endif

// File: common/eth_fd_bus_pkg.sv
/*
	Host bus types of the rule memory path.
	Data word, byte strobe and byte address.
*/
`default_nettype none

`include "eth_fd_params.svh"

package eth_fd_bus_pkg;

	// One host data word.
	typedef logic [`ETH_FD_AXI_WIDTH-1:0] bus_word_t;

	typedef logic [`ETH_FD_AXI_WIDTH/8-1:0] bus_strb_t; // One bit per byte.

	// Byte address, bits 1:0 ignored.
	typedef logic [12:0] bus_addr_t;

endpackage

`default_nettype wire

// File: common/eth_fd_mem_pkg.sv
/*
	Rule memory types. Packed 30-bit lanes, bit mask
	and word address.
*/
`default_nettype none

`include "eth_fd_params.svh"

package eth_fd_mem_pkg;

	// Packed lanes, lane i at bits i*30 and up.
	typedef logic [`ETH_FD_LANES*`ETH_FD_LANE_BITS-1:0] mem_word_t;

	// Set bit takes the new data.
	typedef logic [`ETH_FD_LANES*`ETH_FD_LANE_BITS-1:0] mem_mask_t;

	typedef logic [`ETH_FD_MEM_AWIDTH-1:0] mem_addr_t; // Word address.

endpackage

`default_nettype wire

// File: common/eth_fd_cmd_if.sv
/*
	Command channel from the bus port to the RMW sequencer.
	Single-cycle requests, single-cycle done.
*/
`timescale 1ns/100ps
`default_nettype none

interface eth_fd_cmd_if;
	import eth_fd_mem_pkg::*;

	logic read_req;
	logic write_req;
	mem_addr_t addr;
	mem_mask_t mask;
	mem_word_t wdata;

	logic done;
	mem_word_t rdata; // Stored word, valid with done.

	modport issuer (output read_req, write_req, addr, mask, wdata, input done, rdata);

	modport executor (input read_req, write_req, addr, mask, wdata, output done, rdata);

endinterface

`default_nettype wire

// File: common/eth_fd_mem_if.sv
/*
	Rule memory channel with a req/ack level handshake.
	ack follows req, req drops after ack, ack drops after req.
*/
`timescale 1ns/100ps
`default_nettype none

interface eth_fd_mem_if;
	import eth_fd_mem_pkg::*;

	logic req;
	logic we;
	mem_addr_t addr;
	mem_word_t wdata;

	logic ack;
	mem_word_t rdata; // Held until the next request.

	modport requester (output req, we, addr, wdata, input ack, rdata);

	modport responder (input req, we, addr, wdata, output ack, rdata);

endinterface

`default_nettype wire

// File: design/eth_fd_bus_port.sv
/*
	Host register port. Registers host commands, expands byte strobes
	into bit masks and converts between 32-bit bus lanes and 30-bit
	memory lanes. Requests that arrive while busy are dropped.
*/
`timescale 1ns/100ps
`default_nettype none

`include "eth_fd_params.svh"

module eth_fd_bus_port (
	input logic clk,
	input logic rst_n,
	input logic read_req,
	input logic write_req,
	input eth_fd_bus_pkg::bus_addr_t addr,
	input eth_fd_bus_pkg::bus_strb_t strb,
	input eth_fd_bus_pkg::bus_word_t wdata,
	output eth_fd_bus_pkg::bus_word_t rdata,
	output logic done,
	output logic cmd_drop,
	eth_fd_cmd_if.issuer cmd
);
	import eth_fd_bus_pkg::*;
	import eth_fd_mem_pkg::*;

	localparam int LB = `ETH_FD_LANE_BITS;

	logic busy;
	logic accept;
	bus_word_t strb_bits;
	mem_mask_t mask_packed;
	mem_word_t wdata_packed;
	bus_word_t rdata_unpacked;

	assign accept = (read_req | write_req) & ~busy;

	always_comb begin
		for (int k = 0; k < `ETH_FD_AXI_WIDTH/8; k++) begin
			strb_bits[k*8 +: 8] = {8{strb[k]}};
		end
	end

	// Bits 31:30 of each lane are not stored.
	for (genvar i = 0; i < `ETH_FD_LANES; i++) begin : g_lane
		assign mask_packed[i*LB +: LB] = strb_bits[i*32 +: LB];
		assign wdata_packed[i*LB +: LB] = wdata[i*32 +: LB];
		assign rdata_unpacked[i*32 +: 32] = {{(32-LB){1'b0}}, cmd.rdata[i*LB +: LB]};
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cmd.read_req <= 1'b0;
			cmd.write_req <= 1'b0;
			cmd_drop <= 1'b0;
			done <= 1'b0;
			rdata <= '0;
		end else begin
			cmd.write_req <= accept & write_req;
			cmd.read_req <= accept & read_req;
			cmd_drop <= (read_req | write_req) & busy;
			done <= cmd.done;
			if (accept) begin
				busy <= 1'b1;
			end else if (cmd.done) begin
				busy <= 1'b0;
			end
			if (cmd.done) begin
				rdata <= rdata_unpacked;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			cmd.addr <= addr[12:2]; // Word address.
			cmd.mask <= mask_packed;
			cmd.wdata <= wdata_packed;
		end
	end

	a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		!(cmd.read_req && cmd.write_req));

endmodule

`default_nettype wire

// File: dram_rmw/eth_fd_dram_rmw.sv
/*
	Read-modify-write sequencer on the req/ack memory channel.
	Every command reads the word first, writes merge the new data
	under the bit mask and store it back.
*/
`timescale 1ns/100ps
`default_nettype none

module eth_fd_dram_rmw (
	input logic clk,
	input logic rst_n,
	eth_fd_cmd_if.executor cmd,
	eth_fd_mem_if.requester mem
);
	import eth_fd_mem_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE
	} state_t;

	state_t state;
	logic ack_prev;
	logic ack_fall;
	logic write_pending;
	logic start;
	mem_mask_t mask_q;
	mem_word_t wdata_q;
	mem_word_t rdata_q;

	assign ack_fall = ack_prev & ~mem.ack; // End of a transfer.
	assign start = (state == ST_IDLE) && (cmd.read_req || cmd.write_req);
	assign mem.wdata = wdata_q;
	assign cmd.rdata = rdata_q;

	always_ff @(posedge clk) begin
		if (start) begin
			mem.addr <= cmd.addr;
			mask_q <= cmd.mask;
			wdata_q <= cmd.wdata;
		end else if (state == ST_READ && ack_fall) begin
			// Old bits where the mask is clear.
			wdata_q <= (wdata_q & mask_q) | (mem.rdata & ~mask_q);
		end
		if (state == ST_READ && ack_fall) begin
			rdata_q <= mem.rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			mem.req <= 1'b0;
			mem.we <= 1'b0;
			ack_prev <= 1'b0;
			write_pending <= 1'b0;
			cmd.done <= 1'b0;
		end else begin
			ack_prev <= mem.ack;
			cmd.done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state <= ST_READ;
						mem.we <= 1'b0;
						mem.req <= 1'b1;
						write_pending <= cmd.write_req;
					end
				end
				ST_READ: begin
					if (mem.ack) begin
						mem.req <= 1'b0;
					end else if (ack_fall) begin
						if (write_pending) begin
							state <= ST_WRITE;
							mem.we <= 1'b1;
							mem.req <= 1'b1;
							write_pending <= 1'b0;
						end else begin
							state <= ST_IDLE;
							cmd.done <= 1'b1;
						end
					end
				end
				ST_WRITE: begin
					if (mem.ack) begin
						mem.req <= 1'b0;
					end else if (ack_fall) begin
						state <= ST_IDLE;
						mem.we <= 1'b0;
						cmd.done <= 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	a_idle_no_req: assert property (@(posedge clk) disable iff (!rst_n)
		state == ST_IDLE |-> !mem.req);

	// A command completes only after its last transfer.
	a_done_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd.done) |-> !mem.req);

endmodule

`default_nettype wire

// File: design/eth_fd_rule_mem.sv
/*
	Rule memory model. Answers each req after a fixed latency,
	storing or reading one packed rule word.
*/
`timescale 1ns/100ps
`default_nettype none

`include "eth_fd_params.svh"

module eth_fd_rule_mem (
	input logic clk,
	input logic rst_n,
	eth_fd_mem_if.responder mem
);
	import eth_fd_mem_pkg::*;

	localparam int DEPTH = 1 << `ETH_FD_MEM_AWIDTH;
	localparam int CNT_W = $clog2(`ETH_FD_MEM_LAT + 1);

	mem_word_t rules [DEPTH];
	logic [CNT_W-1:0] lat_cnt;
	logic fire;

	// Last wait cycle of a pending request.
	assign fire = mem.req && !mem.ack && (lat_cnt == CNT_W'(`ETH_FD_MEM_LAT - 1));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem.ack <= 1'b0;
			lat_cnt <= '0;
		end else if (fire) begin
			mem.ack <= 1'b1;
			lat_cnt <= '0;
		end else if (mem.req && !mem.ack) begin
			lat_cnt <= lat_cnt + 1'b1;
		end else if (!mem.req) begin
			mem.ack <= 1'b0; // One cycle after req falls.
			lat_cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			if (mem.we) begin
				rules[mem.addr] <= mem.wdata;
			end else begin
				mem.rdata <= rules[mem.addr];
			end
		end
	end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(mem.ack) |-> mem.req);

endmodule

`default_nettype wire

// File: design/eth_fd_top.sv
/*
	Rule memory path of the Ethernet frame detector.
	Bus port, RMW sequencer and rule memory in a row.
*/
`timescale 1ns/100ps
`default_nettype none

module eth_fd_top (
	input logic clk,
	input logic rst_n,
	input logic read_req,
	input logic write_req,
	input eth_fd_bus_pkg::bus_addr_t addr,
	input eth_fd_bus_pkg::bus_strb_t strb,
	input eth_fd_bus_pkg::bus_word_t wdata,
	output eth_fd_bus_pkg::bus_word_t rdata,
	output logic done,
	output logic cmd_drop
);
	eth_fd_cmd_if cmd_if ();
	eth_fd_mem_if mem_if ();

	eth_fd_bus_port bus_port_i (
		.clk(clk),
		.rst_n(rst_n),
		.read_req(read_req),
		.write_req(write_req),
		.addr(addr),
		.strb(strb),
		.wdata(wdata),
		.rdata(rdata),
		.done(done),
		.cmd_drop(cmd_drop),
		.cmd(cmd_if.issuer)
	);

	eth_fd_dram_rmw dram_rmw_i (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd_if.executor),
		.mem(mem_if.requester)
	);

	eth_fd_rule_mem rule_mem_i (
		.clk(clk),
		.rst_n(rst_n),
		.mem(mem_if.responder)
	);

endmodule

`default_nettype wire

// File: bench/eth_fd_tb.sv
/*
	Testbench for the rule memory path. Applies a table of host reads
	and writes and checks read data against a shadow memory.
*/
`timescale 1ns/100ps
`default_nettype none

`include "eth_fd_params.svh"

module eth_fd_tb;
	import eth_fd_bus_pkg::*;
	import eth_fd_mem_pkg::*;

	localparam int RST_CYCLES = 5;
	localparam int ROW_CYCLES = 20;
	localparam int MARGIN = 100;

	// Write while busy sends a second write that must be dropped.
	typedef enum logic [1:0] {
		OP_WRITE,
		OP_READ,
		OP_BUSY
	} op_t;

	logic clk;
	logic rst_n;
	logic read_req;
	logic write_req;
	bus_addr_t addr;
	bus_strb_t strb;
	bus_word_t wdata;
	bus_word_t rdata;
	logic done;
	logic cmd_drop;

	string row_name[$];
	op_t row_op[$];
	bus_addr_t row_addr[$];
	bus_strb_t row_strb[$];
	bus_word_t row_data[$];

	bus_word_t shadow [1 << `ETH_FD_MEM_AWIDTH]; // Indexed by word address.
	integer seed;
	int err_cnt;
	int pass_cnt;
	int fail_cnt;
	int cycle_cnt;
	int cycle_limit;

	eth_fd_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.read_req(read_req),
		.write_req(write_req),
		.addr(addr),
		.strb(strb),
		.wdata(wdata),
		.rdata(rdata),
		.done(done),
		.cmd_drop(cmd_drop)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("Run stopped after %0d cycles before all tests finished", cycle_cnt);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic bus_word_t lane_fill(input logic [31:0] lane);
		bus_word_t w;
		for (int i = 0; i < `ETH_FD_LANES; i++) begin
			w[i*32 +: 32] = lane;
		end
		return w;
	endfunction

	// Strobed bytes replace old data. Lane bits 31:30 are never stored.
	function automatic bus_word_t merge_write(input bus_word_t old, input bus_word_t data,
			input bus_strb_t s);
		bus_word_t w;
		w = old;
		for (int k = 0; k < `ETH_FD_AXI_WIDTH/8; k++) begin
			if (s[k]) begin
				w[k*8 +: 8] = data[k*8 +: 8];
			end
		end
		for (int i = 0; i < `ETH_FD_LANES; i++) begin
			w[i*32 + 30 +: 2] = 2'b00;
		end
		return w;
	endfunction

	task automatic random_word(output bus_word_t w);
		for (int i = 0; i < `ETH_FD_LANES; i++) begin
			w[i*32 +: 32] = $random(seed);
		end
	endtask

	task automatic add_row(input string name, input op_t op, input bus_addr_t a,
			input bus_strb_t s, input bus_word_t d);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(a);
		row_strb.push_back(s);
		row_data.push_back(d);
	endtask

	task automatic build_table;
		bus_word_t r;
		add_row("wr_full_a", OP_WRITE, 13'h0010, '1, lane_fill(32'hFFFF_FFFF));
		add_row("rd_full_a", OP_READ, 13'h0010, '0, '0);
		random_word(r);
		add_row("wr_full_b", OP_WRITE, 13'h0024, '1, r);
		random_word(r);
		add_row("wr_part_b", OP_WRITE, 13'h0024, bus_strb_t'(4'h5), r);
		add_row("rd_part_b", OP_READ, 13'h0024, '0, '0);
		random_word(r);
		add_row("wr_full_c", OP_WRITE, 13'h1FFC, '1, r);
		random_word(r);
		add_row("wr_alias_c", OP_WRITE, 13'h1FFE, bus_strb_t'(4'h2), r); // Same word.
		add_row("rd_alias_c", OP_READ, 13'h1FFD, '0, '0);
		add_row("rd_full_a2", OP_READ, 13'h0010, '0, '0);
		random_word(r);
		add_row("busy_wr_a", OP_BUSY, 13'h0010, '1, r);
		add_row("rd_busy_a", OP_READ, 13'h0010, '0, '0);
		add_row("wr_part_hi", OP_WRITE, 13'h0024, bus_strb_t'(4'h8), lane_fill(32'hFFAB_0000));
		add_row("rd_part_hi", OP_READ, 13'h0027, '0, '0);
		random_word(r);
		add_row("busy_wr_b", OP_BUSY, 13'h0024, bus_strb_t'(4'h3), r);
		add_row("rd_busy_b", OP_READ, 13'h0024, '0, '0);
		add_row("rd_full_c2", OP_READ, 13'h1FFC, '0, '0);
	endtask

	task automatic pulse(input logic rd, input logic wr, input bus_addr_t a,
			input bus_strb_t s, input bus_word_t d);
		@(negedge clk);
		read_req = rd;
		write_req = wr;
		addr = a;
		strb = s;
		wdata = d;
		@(negedge clk);
		read_req = 1'b0;
		write_req = 1'b0;
	endtask

	// Second write follows on the next cycle while the first is outstanding.
	task automatic pulse_twice(input bus_addr_t a, input bus_strb_t s, input bus_word_t d,
			input bus_word_t d2);
		@(negedge clk);
		write_req = 1'b1;
		addr = a;
		strb = s;
		wdata = d;
		@(negedge clk);
		strb = '1;
		wdata = d2;
		@(negedge clk);
		write_req = 1'b0;
	endtask

	task automatic wait_done(input string name, output logic got_done, output logic got_drop);
		int n;
		got_done = 1'b0;
		got_drop = 1'b0;
		n = 0;
		while (!got_done && n < ROW_CYCLES) begin
			if (cmd_drop === 1'b1) begin
				got_drop = 1'b1;
			end
			if (done === 1'b1) begin
				got_done = 1'b1;
			end else begin
				@(negedge clk);
				n++;
			end
		end
		if (!got_done) begin
			$display("%s: no done pulse within %0d cycles", name, ROW_CYCLES);
			err_cnt++;
		end
	endtask

	task automatic check_word(input string name, input bus_word_t expected,
			input bus_word_t actual);
		if (actual !== expected) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %s expected %b actual %b", name, expected, actual);
			err_cnt++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (err_cnt == err_before) begin
			pass_cnt++;
			$display("PASS %s", name);
		end else begin
			fail_cnt++;
			$display("FAIL %s", name);
		end
	endtask

	task automatic check_idle_after_reset;
		int err_before;
		err_before = err_cnt;
		repeat (4) begin
			@(negedge clk);
			check_flag("idle_after_reset done", 1'b0, done);
			check_flag("idle_after_reset drop", 1'b0, cmd_drop);
			check_word("idle_after_reset rdata", '0, rdata);
		end
		report_test("idle_after_reset", err_before);
	endtask

	task automatic run_row(input int idx);
		int err_before;
		logic got_done;
		logic got_drop;
		bus_addr_t a;
		mem_addr_t widx;
		err_before = err_cnt;
		a = row_addr[idx];
		widx = a[12:2];
		case (row_op[idx])
			OP_WRITE: pulse(1'b0, 1'b1, a, row_strb[idx], row_data[idx]);
			OP_READ: pulse(1'b1, 1'b0, a, row_strb[idx], row_data[idx]);
			default: pulse_twice(a, row_strb[idx], row_data[idx], ~row_data[idx]);
		endcase
		wait_done(row_name[idx], got_done, got_drop);
		check_flag({row_name[idx], " drop"}, row_op[idx] == OP_BUSY, got_drop);
		if (got_done) begin
			if (row_op[idx] == OP_READ) begin
				check_word(row_name[idx], shadow[widx], rdata);
			end else begin
				shadow[widx] = merge_write(shadow[widx], row_data[idx], row_strb[idx]);
			end
			@(negedge clk);
			check_flag({row_name[idx], " done width"}, 1'b0, done); // One-cycle pulse.
		end
		report_test(row_name[idx], err_before);
	endtask

	initial begin
		seed = 60086;
		rst_n = 1'b0;
		read_req = 1'b0;
		write_req = 1'b0;
		addr = '0;
		strb = '0;
		wdata = '0;
		build_table();
		cycle_limit = row_name.size() * ROW_CYCLES + RST_CYCLES + MARGIN;
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		check_idle_after_reset();
		for (int i = 0; i < row_name.size(); i++) begin
			run_row(i);
		end
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: eth_fd.f
+incdir+common
common/eth_fd_bus_pkg.sv
common/eth_fd_mem_pkg.sv
common/eth_fd_cmd_if.sv
common/eth_fd_mem_if.sv
design/eth_fd_bus_port.sv
dram_rmw/eth_fd_dram_rmw.sv
design/eth_fd_rule_mem.sv
design/eth_fd_top.sv
bench/eth_fd_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= eth_fd_tb
BUILD_DIR ?= build
FILELIST ?= eth_fd.f
VFLAGS ?= --binary --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard common/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(BUILD_DIR)
